// ==== design/cpu_pkg.sv ====
package cpu_pkg;

  // Datapath and register index widths
  localparam int WORD_W     = 16;
  localparam int REG_ADDR_W = 4;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Byte step between instructions
  localparam word_t PC_STEP  = 16'd2;
  // Bubble word, SLL r0, r0, 0
  localparam word_t INST_NOP = 16'h4000;

  // RED, PADDSB, BR and PCS decode as no-ops
  typedef enum logic [3:0] {
    ADD, SUB, XOR, RED, SLL, SRA, ROR, PADDSB,
    LW, SW, LLB, LHB, B, BR, PCS, HLT
  } opcode_e;

  typedef enum logic [2:0] {NE, EQ, GT, LT, GE, LE, OV, UN} br_cond_e;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flags_t;

  // Source of an EX operand
  typedef enum logic [1:0] {FWD_REG, FWD_EX_MEM, FWD_WB} fwd_sel_e;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    set_zvn;
    logic    set_z;
    // Second ALU operand is the offset
    logic    use_imm;
    // LLB or LHB byte merge
    logic    byte_merge;
    logic    hlt;
    opcode_e opcode;
  } ctrl_t;

  // Instructions that read the Rs field
  function automatic logic uses_src_a(opcode_e op);
    case (op)
      ADD, SUB, XOR, SLL, SRA, ROR, LW, SW: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Instructions that read a second register
  function automatic logic uses_src_b(opcode_e op);
    case (op)
      ADD, SUB, XOR, SW, LLB, LHB: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // SW, LLB and LHB read Rd as the second source
  function automatic reg_addr_t src_b_addr(word_t inst);
    case (opcode_e'(inst[15:12]))
      SW, LLB, LHB: return inst[11:8];
      default: return inst[3:0];
    endcase
  endfunction

endpackage

// ==== design/stage_ifs.sv ====
// IF/ID contents
interface if_id_if;
  cpu_pkg::word_t inst;
  cpu_pkg::word_t next_pc;
  logic           valid;

  modport producer (output inst, next_pc, valid);
  modport consumer (input inst, next_pc, valid);
endinterface

// ID/EX contents
interface id_ex_if;
  cpu_pkg::ctrl_t     ctrl;
  cpu_pkg::word_t     rs_val;
  cpu_pkg::word_t     rt_val;
  // Offset, or imm8 already in its byte lane
  cpu_pkg::word_t     imm;
  logic [3:0]         shamt;
  cpu_pkg::reg_addr_t rs;
  cpu_pkg::reg_addr_t rt;
  cpu_pkg::reg_addr_t rd;

  modport producer (output ctrl, rs_val, rt_val, imm, shamt, rs, rt, rd);
  modport consumer (input ctrl, rs_val, rt_val, imm, shamt, rs, rt, rd);
endinterface

// EX/MEM contents
interface ex_mem_if;
  cpu_pkg::word_t     result;
  cpu_pkg::word_t     store_data;
  cpu_pkg::reg_addr_t rd;
  cpu_pkg::ctrl_t     ctrl;

  modport producer (output result, store_data, rd, ctrl);
  modport consumer (input result, store_data, rd, ctrl);
endinterface

// Write-back port out of MEM/WB
interface wb_if;
  logic               reg_write;
  cpu_pkg::reg_addr_t rd;
  cpu_pkg::word_t     data;
  logic               hlt;

  modport producer (output reg_write, rd, data, hlt);
  modport consumer (input reg_write, rd, data, hlt);
endinterface

// ==== design/alu.sv ====
module alu (
  input  cpu_pkg::opcode_e op,
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  input  logic [3:0]       shamt,
  output cpu_pkg::word_t   result,
  output cpu_pkg::flags_t  flags_out
);

  cpu_pkg::word_t sum;
  cpu_pkg::word_t diff;
  logic           add_ovf;
  logic           sub_ovf;
  logic [31:0]    rot;

  // Clamp toward the sign of a on overflow
  function automatic cpu_pkg::word_t saturate(cpu_pkg::word_t raw, logic ovf, logic neg);
    if (!ovf) return raw;
    return neg ? 16'h8000 : 16'h7FFF;
  endfunction

  assign sum  = a + b;
  assign diff = a - b;

  // Signed overflow detection
  assign add_ovf = (a[15] == b[15]) && (sum[15] != a[15]);
  assign sub_ovf = (a[15] != b[15]) && (diff[15] != a[15]);

  // Rotate via doubled word
  assign rot = {a, a} >> shamt;

  always_comb begin
    flags_out.v = 1'b0;
    case (op)
      cpu_pkg::ADD: begin
        result      = saturate(sum, add_ovf, a[15]);
        flags_out.v = add_ovf;
      end
      cpu_pkg::SUB: begin
        result      = saturate(diff, sub_ovf, a[15]);
        flags_out.v = sub_ovf;
      end
      cpu_pkg::XOR: result = a ^ b;
      cpu_pkg::SLL: result = a << shamt;
      cpu_pkg::SRA: result = cpu_pkg::word_t'($signed(a) >>> shamt);
      cpu_pkg::ROR: result = rot[15:0];
      // LW/SW address, plain add
      default:      result = sum;
    endcase
    flags_out.z = (result == '0);
    flags_out.n = result[15];
  end

endmodule

// ==== design/fetch_stage.sv ====
module fetch_stage (
  input  logic             clk,
  input  logic             arst_n,
  input  cpu_pkg::word_t   imem_data,
  input  logic             stall,
  input  logic             branch_taken,
  input  cpu_pkg::word_t   branch_target,
  output cpu_pkg::word_t   pc,
  if_id_if.producer        if_id
);

  cpu_pkg::word_t pc_plus;
  logic           fetch_hlt;

  assign pc_plus = pc + cpu_pkg::PC_STEP;

  // Halt word at pc and no branch discarding it
  assign fetch_hlt = (cpu_pkg::opcode_e'(imem_data[15:12]) == cpu_pkg::HLT) && !branch_taken;

  // PC and IF/ID control
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc          <= '0;
      if_id.valid <= 1'b0;
      if_id.inst  <= cpu_pkg::INST_NOP;
    end else if (!stall) begin
      if (branch_taken) begin
        // Squash the wrong-path fetch
        pc          <= branch_target;
        if_id.valid <= 1'b0;
        if_id.inst  <= cpu_pkg::INST_NOP;
      end else begin
        // PC parks on a halt
        if (!fetch_hlt) pc <= pc_plus;
        if_id.valid <= 1'b1;
        if_id.inst  <= imem_data;
      end
    end
  end

  // Return address travels with the instruction
  always_ff @(posedge clk) begin
    if (!stall) if_id.next_pc <= pc_plus;
  end

endmodule

// ==== design/decode_stage.sv ====
module decode_stage (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 stall,
  if_id_if.consumer            if_id,
  output cpu_pkg::reg_addr_t   rf_rs_addr,
  output cpu_pkg::reg_addr_t   rf_rt_addr,
  input  cpu_pkg::word_t       rf_rs_val,
  input  cpu_pkg::word_t       rf_rt_val,
  input  cpu_pkg::flags_t      flags,
  output logic                 branch_taken,
  output cpu_pkg::word_t       branch_target,
  id_ex_if.producer            id_ex
);

  cpu_pkg::opcode_e  op;
  cpu_pkg::br_cond_e cond;
  cpu_pkg::word_t    imm_dec;
  cpu_pkg::word_t    br_off;
  logic              cond_true;

  function automatic cpu_pkg::ctrl_t decode_ctrl(cpu_pkg::opcode_e opc);
    cpu_pkg::ctrl_t c;
    c = '0;
    c.opcode = opc;
    case (opc)
      cpu_pkg::ADD, cpu_pkg::SUB: begin
        c.reg_write = 1'b1;
        c.set_zvn   = 1'b1;
      end
      cpu_pkg::XOR, cpu_pkg::SLL, cpu_pkg::SRA, cpu_pkg::ROR: begin
        c.reg_write = 1'b1;
        c.set_z     = 1'b1;
      end
      cpu_pkg::LW: begin
        c.reg_write = 1'b1;
        c.mem_read  = 1'b1;
        c.use_imm   = 1'b1;
      end
      cpu_pkg::SW: begin
        c.mem_write = 1'b1;
        c.use_imm   = 1'b1;
      end
      cpu_pkg::LLB, cpu_pkg::LHB: begin
        c.reg_write  = 1'b1;
        c.byte_merge = 1'b1;
      end
      cpu_pkg::HLT: c.hlt = 1'b1;
      // Dropped opcodes fall through as no-ops
      default: c.hlt = 1'b0;
    endcase
    return c;
  endfunction

  assign op   = cpu_pkg::opcode_e'(if_id.inst[15:12]);
  assign cond = cpu_pkg::br_cond_e'(if_id.inst[11:9]);

  // Register file read addresses
  assign rf_rs_addr = if_id.inst[7:4];
  assign rf_rt_addr = cpu_pkg::src_b_addr(if_id.inst);

  // Byte-placed imm8 or scaled imm4
  always_comb begin
    case (op)
      cpu_pkg::LLB: imm_dec = {8'h00, if_id.inst[7:0]};
      cpu_pkg::LHB: imm_dec = {if_id.inst[7:0], 8'h00};
      default:      imm_dec = {{11{if_id.inst[3]}}, if_id.inst[3:0], 1'b0};
    endcase
  end

  // Condition against the committed flags
  always_comb begin
    case (cond)
      cpu_pkg::NE: cond_true = !flags.z;
      cpu_pkg::EQ: cond_true = flags.z;
      cpu_pkg::GT: cond_true = !flags.z && !flags.n;
      cpu_pkg::LT: cond_true = flags.n;
      cpu_pkg::GE: cond_true = flags.z || (!flags.z && !flags.n);
      cpu_pkg::LE: cond_true = flags.n || flags.z;
      cpu_pkg::OV: cond_true = flags.v;
      default:     cond_true = 1'b1;
    endcase
  end

  // Target relative to PC+2
  assign br_off        = {{6{if_id.inst[8]}}, if_id.inst[8:0], 1'b0};
  assign branch_target = if_id.next_pc + br_off;
  // No decision while flags are still in flight
  assign branch_taken  = if_id.valid && (op == cpu_pkg::B) && cond_true && !stall;

  // ID/EX control, bubble on stall or empty slot
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex.ctrl <= '0;
    end else if (stall || !if_id.valid) begin
      id_ex.ctrl <= '0;
    end else begin
      id_ex.ctrl <= decode_ctrl(op);
    end
  end

  // ID/EX operands
  always_ff @(posedge clk) begin
    id_ex.rs_val <= rf_rs_val;
    id_ex.rt_val <= rf_rt_val;
    id_ex.imm    <= imm_dec;
    id_ex.shamt  <= if_id.inst[3:0];
    id_ex.rs     <= rf_rs_addr;
    id_ex.rt     <= rf_rt_addr;
    id_ex.rd     <= if_id.inst[11:8];
  end

endmodule

// ==== design/reg_file.sv ====
module reg_file (
  input  logic               clk,
  input  logic               arst_n,
  input  cpu_pkg::reg_addr_t rs_addr,
  input  cpu_pkg::reg_addr_t rt_addr,
  output cpu_pkg::word_t     rs_val,
  output cpu_pkg::word_t     rt_val,
  wb_if.consumer             wb
);

  // r0 has no storage
  cpu_pkg::word_t regs [1:15];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 16; i++) regs[i] <= '0;
    end else if (wb.reg_write && (wb.rd != '0)) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Zero register, then write-through of the value being retired
  assign rs_val = (rs_addr == '0) ? '0 :
                  (wb.reg_write && (wb.rd == rs_addr)) ? wb.data : regs[rs_addr];
  assign rt_val = (rt_addr == '0) ? '0 :
                  (wb.reg_write && (wb.rd == rt_addr)) ? wb.data : regs[rt_addr];

endmodule

// ==== design/hazard_unit.sv ====
module hazard_unit (
  if_id_if.consumer           if_id,
  id_ex_if.consumer           id_ex,
  ex_mem_if.consumer          ex_mem,
  wb_if.consumer              wb,
  output logic                stall,
  output cpu_pkg::fwd_sel_e   fwd_a,
  output cpu_pkg::fwd_sel_e   fwd_b,
  output logic                fwd_store
);

  cpu_pkg::opcode_e   op;
  cpu_pkg::reg_addr_t src_a;
  cpu_pkg::reg_addr_t src_b;
  logic               load_use;
  logic               flag_branch;
  logic               ex_ok;
  logic               wb_ok;

  // Youngest producer wins
  function automatic cpu_pkg::fwd_sel_e pick(cpu_pkg::reg_addr_t src, logic ex_wr,
                                             cpu_pkg::reg_addr_t ex_rd, logic wb_wr,
                                             cpu_pkg::reg_addr_t wb_rd);
    if (ex_wr && (ex_rd == src)) return cpu_pkg::FWD_EX_MEM;
    if (wb_wr && (wb_rd == src)) return cpu_pkg::FWD_WB;
    return cpu_pkg::FWD_REG;
  endfunction

  assign op    = cpu_pkg::opcode_e'(if_id.inst[15:12]);
  assign src_a = if_id.inst[7:4];
  assign src_b = cpu_pkg::src_b_addr(if_id.inst);

  // Load in EX feeding the instruction in ID
  assign load_use = if_id.valid && id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
                    ((cpu_pkg::uses_src_a(op) && (src_a == id_ex.rd)) ||
                     (cpu_pkg::uses_src_b(op) && (src_b == id_ex.rd)));

  // Conditional branch waits for flags from EX
  assign flag_branch = if_id.valid && (op == cpu_pkg::B) &&
                       (cpu_pkg::br_cond_e'(if_id.inst[11:9]) != cpu_pkg::UN) &&
                       (id_ex.ctrl.set_zvn || id_ex.ctrl.set_z);

  assign stall = load_use || flag_branch;

  // Producers that actually write a real register
  assign ex_ok = ex_mem.ctrl.reg_write && (ex_mem.rd != '0);
  assign wb_ok = wb.reg_write && (wb.rd != '0);

  assign fwd_a = pick(id_ex.rs, ex_ok, ex_mem.rd, wb_ok, wb.rd);
  assign fwd_b = pick(id_ex.rt, ex_ok, ex_mem.rd, wb_ok, wb.rd);

  // Store in MEM whose data register is retiring now
  assign fwd_store = ex_mem.ctrl.mem_write && wb_ok && (wb.rd == ex_mem.rd);

endmodule

// ==== design/execute_stage.sv ====
module execute_stage (
  input  logic                clk,
  input  logic                arst_n,
  id_ex_if.consumer           id_ex,
  input  cpu_pkg::fwd_sel_e   fwd_a,
  input  cpu_pkg::fwd_sel_e   fwd_b,
  input  logic                fwd_store,
  output cpu_pkg::flags_t     flags,
  ex_mem_if.producer          ex_mem,
  wb_if.consumer              wb
);

  cpu_pkg::word_t  op_a;
  cpu_pkg::word_t  op_b;
  cpu_pkg::word_t  alu_a;
  cpu_pkg::word_t  alu_b;
  cpu_pkg::word_t  alu_res;
  cpu_pkg::word_t  merged;
  cpu_pkg::word_t  ex_result;
  cpu_pkg::word_t  store_q;
  cpu_pkg::flags_t alu_flags;

  function automatic cpu_pkg::word_t fwd_val(cpu_pkg::fwd_sel_e sel, cpu_pkg::word_t reg_v,
                                             cpu_pkg::word_t ex_v, cpu_pkg::word_t wb_v);
    case (sel)
      cpu_pkg::FWD_EX_MEM: return ex_v;
      cpu_pkg::FWD_WB:     return wb_v;
      default:             return reg_v;
    endcase
  endfunction

  // Operand forwarding
  assign op_a = fwd_val(fwd_a, id_ex.rs_val, ex_mem.result, wb.data);
  assign op_b = fwd_val(fwd_b, id_ex.rt_val, ex_mem.result, wb.data);

  // Word-aligned base plus offset for LW/SW
  assign alu_a = id_ex.ctrl.use_imm ? {op_a[15:1], 1'b0} : op_a;
  assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : op_b;

  alu u_alu (
    .op        (id_ex.ctrl.opcode),
    .a         (alu_a),
    .b         (alu_b),
    .shamt     (id_ex.shamt),
    .result    (alu_res),
    .flags_out (alu_flags)
  );

  // Keep the other byte of Rd
  assign merged = (id_ex.ctrl.opcode == cpu_pkg::LHB) ? ((op_b & 16'h00FF) | id_ex.imm) :
                                                        ((op_b & 16'hFF00) | id_ex.imm);
  assign ex_result = id_ex.ctrl.byte_merge ? merged : alu_res;

  // Flag register, Z only for logic and shift ops
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flags <= '0;
    end else if (id_ex.ctrl.set_zvn) begin
      flags <= alu_flags;
    end else if (id_ex.ctrl.set_z) begin
      flags.z <= alu_flags.z;
    end
  end

  // EX/MEM control
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) ex_mem.ctrl <= '0;
    else ex_mem.ctrl <= id_ex.ctrl;
  end

  // EX/MEM payload
  always_ff @(posedge clk) begin
    ex_mem.result <= ex_result;
    ex_mem.rd     <= id_ex.rd;
    store_q       <= op_b;
  end

  // Late store data from the retiring instruction
  assign ex_mem.store_data = fwd_store ? wb.data : store_q;

endmodule

// ==== design/memory_stage.sv ====
module memory_stage (
  input  logic            clk,
  input  logic            arst_n,
  ex_mem_if.consumer      ex_mem,
  output cpu_pkg::word_t  dmem_addr,
  output cpu_pkg::word_t  dmem_wdata,
  output logic            dmem_we,
  input  cpu_pkg::word_t  dmem_rdata,
  output logic            hlt,
  wb_if.producer          wb
);

  logic           mem_read_q;
  cpu_pkg::word_t result_q;
  cpu_pkg::word_t load_q;

  // Data port straight from EX/MEM
  assign dmem_addr  = ex_mem.result;
  assign dmem_wdata = ex_mem.store_data;
  // Bubbles carry zero ctrl
  assign dmem_we    = ex_mem.ctrl.mem_write;

  // MEM/WB control
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb.reg_write <= 1'b0;
      mem_read_q   <= 1'b0;
      wb.hlt       <= 1'b0;
    end else begin
      wb.reg_write <= ex_mem.ctrl.reg_write;
      mem_read_q   <= ex_mem.ctrl.mem_read;
      wb.hlt       <= ex_mem.ctrl.hlt;
    end
  end

  // MEM/WB payload
  always_ff @(posedge clk) begin
    wb.rd    <= ex_mem.rd;
    result_q <= ex_mem.result;
    load_q   <= dmem_rdata;
  end

  // Write-back select
  assign wb.data = mem_read_q ? load_q : result_q;
  assign hlt     = wb.hlt;

endmodule

// ==== design/cpu.sv ====
module cpu (
  input  logic           clk,
  input  logic           arst_n,
  input  cpu_pkg::word_t imem_data,
  input  cpu_pkg::word_t dmem_rdata,
  output cpu_pkg::word_t pc,
  output cpu_pkg::word_t dmem_addr,
  output cpu_pkg::word_t dmem_wdata,
  output logic           dmem_we,
  output logic           hlt
);

  if_id_if  if_id ();
  id_ex_if  id_ex ();
  ex_mem_if ex_mem ();
  wb_if     wb ();

  // Hazard controls
  logic              stall;
  logic              fwd_store;
  cpu_pkg::fwd_sel_e fwd_a;
  cpu_pkg::fwd_sel_e fwd_b;

  // Branch resolved in decode
  logic              branch_taken;
  cpu_pkg::word_t    branch_target;
  cpu_pkg::flags_t   flags;

  // Register file read ports
  cpu_pkg::reg_addr_t rf_rs_addr;
  cpu_pkg::reg_addr_t rf_rt_addr;
  cpu_pkg::word_t     rf_rs_val;
  cpu_pkg::word_t     rf_rt_val;

  fetch_stage u_fetch (
    .clk (clk), .arst_n (arst_n), .imem_data (imem_data), .stall (stall),
    .branch_taken (branch_taken), .branch_target (branch_target), .pc (pc), .if_id (if_id)
  );

  decode_stage u_decode (
    .clk (clk), .arst_n (arst_n), .stall (stall), .if_id (if_id),
    .rf_rs_addr (rf_rs_addr), .rf_rt_addr (rf_rt_addr),
    .rf_rs_val (rf_rs_val), .rf_rt_val (rf_rt_val), .flags (flags),
    .branch_taken (branch_taken), .branch_target (branch_target), .id_ex (id_ex)
  );

  reg_file u_reg_file (
    .clk (clk), .arst_n (arst_n), .rs_addr (rf_rs_addr), .rt_addr (rf_rt_addr),
    .rs_val (rf_rs_val), .rt_val (rf_rt_val), .wb (wb)
  );

  hazard_unit u_hazard (
    .if_id (if_id), .id_ex (id_ex), .ex_mem (ex_mem), .wb (wb), .stall (stall),
    .fwd_a (fwd_a), .fwd_b (fwd_b), .fwd_store (fwd_store)
  );

  execute_stage u_execute (
    .clk (clk), .arst_n (arst_n), .id_ex (id_ex), .fwd_a (fwd_a), .fwd_b (fwd_b),
    .fwd_store (fwd_store), .flags (flags), .ex_mem (ex_mem), .wb (wb)
  );

  memory_stage u_memory (
    .clk (clk), .arst_n (arst_n), .ex_mem (ex_mem), .dmem_addr (dmem_addr),
    .dmem_wdata (dmem_wdata), .dmem_we (dmem_we), .dmem_rdata (dmem_rdata),
    .hlt (hlt), .wb (wb)
  );

endmodule

// ==== testbench/cpu_sva.sv ====
module cpu_sva (
  input logic           clk,
  input logic           arst_n,
  input cpu_pkg::word_t pc,
  input logic           dmem_we,
  input logic           hlt
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failures seen so far, read by the testbench at the end
  int unsigned fail_count = 0;

  // No store leaves the core during reset
  we_low_in_reset: assert property (@(posedge clk) !arst_n |-> !dmem_we)
    else begin
      $error("dmem_we high while arst_n is low");
      fail_count++;
    end

  // Halt is sticky
  hlt_sticky: assert property (@(posedge clk) disable iff (!arst_n) hlt |=> hlt)
    else begin
      $error("hlt fell after rising");
      fail_count++;
    end

  // Fetch address parked while halted
  pc_frozen: assert property (@(posedge clk) disable iff (!arst_n) hlt |=> $stable(pc))
    else begin
      $error("pc changed while hlt is high");
      fail_count++;
    end

  we_known: assert property (@(posedge clk) !$isunknown(dmem_we))
    else begin
      $error("dmem_we is unknown");
      fail_count++;
    end

endmodule

// Attached to every cpu instance
bind cpu cpu_sva u_sva (.clk(clk), .arst_n(arst_n), .pc(pc), .dmem_we(dmem_we), .hlt(hlt));

// ==== testbench/tb_cpu.sv ====
module tb_cpu;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int  SEED          = 55017;
  localparam time CLK_PER       = 8ns;
  localparam time DRIVE_DLY     = 1ns;
  localparam int  MEM_WORDS     = 256;
  localparam int  MAX_STEPS     = 4096;
  localparam int  WDOG_PER_INST = 40;

  logic           clk;
  logic           arst_n;
  cpu_pkg::word_t imem_data;
  cpu_pkg::word_t dmem_rdata;
  cpu_pkg::word_t pc;
  cpu_pkg::word_t dmem_addr;
  cpu_pkg::word_t dmem_wdata;
  logic           dmem_we;
  logic           hlt;

  // Word indexed memories, byte address bits 8:1
  cpu_pkg::word_t imem [MEM_WORDS];
  cpu_pkg::word_t dmem [MEM_WORDS];
  cpu_pkg::word_t ref_mem [MEM_WORDS];
  int             prog_len;
  // Predicted stores, oldest first
  cpu_pkg::word_t exp_addr [$];
  cpu_pkg::word_t exp_data [$];
  cpu_pkg::word_t halt_pc;
  bit             ref_halted;

  cpu u_dut (
    .clk (clk), .arst_n (arst_n), .imem_data (imem_data), .dmem_rdata (dmem_rdata),
    .pc (pc), .dmem_addr (dmem_addr), .dmem_wdata (dmem_wdata), .dmem_we (dmem_we),
    .hlt (hlt)
  );

  // Single-cycle combinational memory ports
  assign imem_data  = imem[pc[8:1]];
  assign dmem_rdata = dmem[dmem_addr[8:1]];

  initial begin
    clk = 1'b0;
    forever #(CLK_PER / 2) clk = ~clk;
  end

  task automatic fail_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_error(string msg);
    $display("ERR %0t: %s", $time, msg);
    fail_run();
  endtask

  task automatic check_store(cpu_pkg::word_t addr, cpu_pkg::word_t data);
    cpu_pkg::word_t exp_a;
    cpu_pkg::word_t exp_d;
    if (exp_addr.size() == 0) begin
      report_error($sformatf("unexpected store of %h to %h", data, addr));
    end else begin
      exp_a = exp_addr.pop_front();
      exp_d = exp_data.pop_front();
      if (addr !== exp_a || data !== exp_d)
        report_error($sformatf("store %h to %h, expected %h to %h", data, addr, exp_d, exp_a));
    end
  endtask

  task automatic check_mem(cpu_pkg::word_t idx, cpu_pkg::word_t got, cpu_pkg::word_t exp);
    if (got !== exp)
      report_error($sformatf("data word %0d is %h, expected %h", idx, got, exp));
  endtask

  task automatic check_halt(cpu_pkg::word_t pc_at_halt);
    if (exp_addr.size() != 0)
      report_error($sformatf("%0d expected stores missing at halt", exp_addr.size()));
    if (pc_at_halt !== halt_pc)
      report_error($sformatf("halt pc %h, expected %h", pc_at_halt, halt_pc));
    // Parked for ten more cycles
    repeat (10) begin
      @(negedge clk);
      if (pc !== pc_at_halt) report_error($sformatf("pc moved to %h after halt", pc));
    end
  endtask

  // Both bytes follow the word index
  function automatic cpu_pkg::word_t fill_word(int i);
    return {8'(i), 8'(i) ^ 8'h3C};
  endfunction

  function automatic logic cond_met(cpu_pkg::br_cond_e c, cpu_pkg::flags_t f);
    case (c)
      cpu_pkg::NE: return !f.z;
      cpu_pkg::EQ: return f.z;
      cpu_pkg::GT: return !f.z && !f.n;
      cpu_pkg::LT: return f.n;
      cpu_pkg::GE: return f.z || (!f.z && !f.n);
      cpu_pkg::LE: return f.n || f.z;
      cpu_pkg::OV: return f.v;
      default:     return 1'b1;
    endcase
  endfunction

  // ISA-level interpreter, returns the HLT address
  function automatic cpu_pkg::word_t cpu_ref_run();
    cpu_pkg::word_t   r [16];
    cpu_pkg::flags_t  f;
    cpu_pkg::word_t   cur;
    cpu_pkg::word_t   nxt;
    cpu_pkg::word_t   ins;
    cpu_pkg::word_t   a;
    cpu_pkg::word_t   b;
    cpu_pkg::word_t   res;
    cpu_pkg::word_t   addr;
    cpu_pkg::opcode_e op;
    int               sum;
    int               sh;
    for (int i = 0; i < 16; i++) r[i] = '0;
    for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = fill_word(i);
    f = '0;
    cur = '0;
    ref_halted = 1'b0;
    for (int step = 0; step < MAX_STEPS; step++) begin
      ins  = imem[cur[8:1]];
      op   = cpu_pkg::opcode_e'(ins[15:12]);
      a    = r[ins[7:4]];
      b    = r[ins[3:0]];
      sh   = ins[3:0];
      nxt  = cur + 16'd2;
      // Even base plus imm4 words
      addr = (a & 16'hFFFE) + cpu_pkg::word_t'(int'($signed(ins[3:0])) * 2);
      case (op)
        cpu_pkg::ADD, cpu_pkg::SUB: begin
          sum = (op == cpu_pkg::ADD) ? int'($signed(a)) + int'($signed(b)) :
                                       int'($signed(a)) - int'($signed(b));
          f.v = (sum > 32767) || (sum < -32768);
          res = (sum > 32767) ? 16'h7FFF : (sum < -32768) ? 16'h8000 : cpu_pkg::word_t'(sum);
          f.z = (res == '0);
          f.n = res[15];
          r[ins[11:8]] = res;
        end
        cpu_pkg::XOR, cpu_pkg::SLL, cpu_pkg::SRA, cpu_pkg::ROR: begin
          case (op)
            cpu_pkg::XOR: res = a ^ b;
            cpu_pkg::SLL: res = a << sh;
            cpu_pkg::SRA: res = cpu_pkg::word_t'($signed(a) >>> sh);
            default:      res = (a >> sh) | (a << (16 - sh));
          endcase
          // Z only
          f.z = (res == '0);
          r[ins[11:8]] = res;
        end
        cpu_pkg::LW: r[ins[11:8]] = ref_mem[addr[8:1]];
        cpu_pkg::SW: begin
          ref_mem[addr[8:1]] = r[ins[11:8]];
          exp_addr.push_back(addr);
          exp_data.push_back(r[ins[11:8]]);
        end
        cpu_pkg::LLB: r[ins[11:8]] = (r[ins[11:8]] & 16'hFF00) | {8'h00, ins[7:0]};
        cpu_pkg::LHB: r[ins[11:8]] = (r[ins[11:8]] & 16'h00FF) | {ins[7:0], 8'h00};
        cpu_pkg::B: begin
          if (cond_met(cpu_pkg::br_cond_e'(ins[11:9]), f))
            nxt = nxt + cpu_pkg::word_t'(int'($signed(ins[8:0])) * 2);
        end
        cpu_pkg::HLT: begin
          ref_halted = 1'b1;
          return cur;
        end
        // RED, PADDSB, BR, PCS do nothing
        default: ;
      endcase
      r[0] = '0;
      cur  = nxt;
    end
    return cur;
  endfunction

  function automatic cpu_pkg::word_t enc(cpu_pkg::opcode_e op, logic [3:0] rd,
                                         logic [3:0] rs, logic [3:0] lo);
    return {op, rd, rs, lo};
  endfunction

  function automatic void emit(cpu_pkg::word_t w);
    imem[prog_len] = w;
    prog_len++;
  endfunction

  // LLB then LHB gives any constant
  function automatic void load_const(logic [3:0] rd, cpu_pkg::word_t v);
    emit(enc(cpu_pkg::LLB, rd, v[7:4], v[3:0]));
    emit(enc(cpu_pkg::LHB, rd, v[15:12], v[11:8]));
  endfunction

  function automatic void build_program();
    cpu_pkg::word_t setter [4];
    // Back-to-back ALU chain on random operands
    load_const(1, cpu_pkg::word_t'($urandom));
    load_const(2, cpu_pkg::word_t'($urandom));
    emit(enc(cpu_pkg::ADD, 4, 1, 2));
    emit(enc(cpu_pkg::XOR, 4, 4, 1));
    emit(enc(cpu_pkg::SUB, 5, 4, 2));
    emit(enc(cpu_pkg::SLL, 5, 5, 3));
    emit(enc(cpu_pkg::SRA, 6, 5, 2));
    emit(enc(cpu_pkg::ROR, 6, 6, 5));
    emit(enc(cpu_pkg::SW, 4, 0, 0));
    emit(enc(cpu_pkg::SW, 5, 0, 1));
    emit(enc(cpu_pkg::SW, 6, 0, 2));
    // Load-use into ALU and into store data
    emit(enc(cpu_pkg::LW, 10, 0, 1));
    emit(enc(cpu_pkg::ADD, 11, 10, 1));
    emit(enc(cpu_pkg::SW, 11, 0, 3));
    emit(enc(cpu_pkg::LW, 12, 0, 0));
    emit(enc(cpu_pkg::SW, 12, 0, 4));
    // Random constants stored right after LHB, negative offsets
    for (int k = 0; k < 3; k++) begin
      load_const(13, cpu_pkg::word_t'($urandom));
      emit(enc(cpu_pkg::SW, 13, 0, 4'(15 - k)));
    end
    // Saturation both ways
    load_const(3, 16'h7000);
    load_const(13, 16'h9000);
    emit(enc(cpu_pkg::ADD, 11, 3, 3));
    emit(enc(cpu_pkg::SW, 11, 0, 4'hC));
    emit(enc(cpu_pkg::SUB, 12, 13, 3));
    emit(enc(cpu_pkg::SW, 12, 0, 4'hB));
    // r0 stays zero
    emit(enc(cpu_pkg::ADD, 0, 1, 2));
    emit(enc(cpu_pkg::LLB, 0, 4'h5, 4'h5));
    emit(enc(cpu_pkg::SW, 0, 0, 5));
    // Branch matrix operands, store pointer and marker
    load_const(1, 16'd5);
    load_const(2, 16'd3);
    load_const(7, 16'h0100);
    load_const(8, 16'd2);
    load_const(9, cpu_pkg::word_t'($urandom));
    // Zero, positive, negative, overflow
    setter[0] = enc(cpu_pkg::SUB, 5, 1, 1);
    setter[1] = enc(cpu_pkg::ADD, 5, 1, 2);
    setter[2] = enc(cpu_pkg::SUB, 5, 2, 1);
    setter[3] = enc(cpu_pkg::ADD, 5, 3, 3);
    for (int c = 0; c < 8; c++) begin
      for (int k = 0; k < 4; k++) begin
        emit(enc(cpu_pkg::ADD, 7, 7, 8));
        emit(setter[k]);
        // Taken skips the store
        emit({cpu_pkg::B, cpu_pkg::br_cond_e'(c), 9'd1});
        emit(enc(cpu_pkg::SW, 9, 7, 0));
      end
    end
    emit(enc(cpu_pkg::HLT, 0, 0, 0));
    // Must never execute
    emit(enc(cpu_pkg::SW, 9, 0, 6));
  endfunction

  // Store checker, also updates the data memory model
  always @(negedge clk) begin
    if (dmem_we === 1'b1) begin
      check_store(dmem_addr, dmem_wdata);
      dmem[dmem_addr[8:1]] = dmem_wdata;
    end
  end

  // Watchdog scaled by program length
  initial begin
    @(posedge arst_n);
    repeat (WDOG_PER_INST * prog_len) @(posedge clk);
    $display("Processor never halted within %0d cycles", WDOG_PER_INST * prog_len);
    fail_run();
  end

  initial begin
    void'($urandom(SEED));
    arst_n   = 1'b0;
    prog_len = 0;
    // Unused program words are HLT, tagged with their index
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = {cpu_pkg::HLT, 4'h0, 8'(i)};
      dmem[i] = fill_word(i);
    end
    build_program();
    halt_pc = cpu_ref_run();
    if (!ref_halted) begin
      $display("Reference interpreter never reached HLT");
      fail_run();
    end
    repeat (5) @(posedge clk);
    #DRIVE_DLY arst_n = 1'b1;
    while (hlt !== 1'b1) @(negedge clk);
    check_halt(pc);
    for (int i = 0; i < MEM_WORDS; i++) check_mem(cpu_pkg::word_t'(i), dmem[i], ref_mem[i]);
    if (u_dut.u_sva.fail_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("%0d bound assertion failures", u_dut.u_sva.fail_count);
      fail_run();
    end
  end

endmodule

// ==== sim.f ====
design/cpu_pkg.sv
design/stage_ifs.sv
design/alu.sv
design/fetch_stage.sv
design/decode_stage.sv
design/reg_file.sv
design/hazard_unit.sv
design/execute_stage.sv
design/memory_stage.sv
design/cpu.sv
testbench/cpu_sva.sv
testbench/tb_cpu.sv
